// File: include/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DECODE_XLEN   32
`define DECODE_NREGS  32
`define DECODE_A0     5'd10

// Opcodes
`define DECODE_OP_R      7'b0110011
`define DECODE_OP_I      7'b0010011
`define DECODE_OP_LOAD   7'b0000011
`define DECODE_OP_STORE  7'b0100011
`define DECODE_OP_BRANCH 7'b1100011
`define DECODE_OP_JAL    7'b1101111
`define DECODE_OP_JALR   7'b1100111
`define DECODE_OP_LUI    7'b0110111

// ALU codes
`define DECODE_ALU_ADD 3'd0
`define DECODE_ALU_SUB 3'd1
`define DECODE_ALU_AND 3'd2
`define DECODE_ALU_OR  3'd3
`define DECODE_ALU_XOR 3'd4
`define DECODE_ALU_SLT 3'd5
`define DECODE_ALU_SLL 3'd6
`define DECODE_ALU_SRL 3'd7

// funct3 values
`define DECODE_F3_ADD  3'b000
`define DECODE_F3_SLL  3'b001
`define DECODE_F3_SLT  3'b010
`define DECODE_F3_XOR  3'b100
`define DECODE_F3_SRL  3'b101
`define DECODE_F3_OR   3'b110
`define DECODE_F3_AND  3'b111
`define DECODE_F3_LW   3'b010
`define DECODE_F3_SB   3'b000
`define DECODE_F3_SH   3'b001
`define DECODE_F3_SW   3'b010
`define DECODE_F3_BEQ  3'b000
`define DECODE_F3_BNE  3'b001
`define DECODE_F3_JALR 3'b000

// Immediate formats
`define DECODE_IMM_I 3'd0
`define DECODE_IMM_S 3'd1
`define DECODE_IMM_B 3'd2
`define DECODE_IMM_J 3'd3
`define DECODE_IMM_U 3'd4

`endif

// File: design/decodePkg.sv
`default_nettype none

package decodePkg;

    // Instruction, register data and immediate
    typedef logic [31:0] word_t;

    // Register number
    typedef logic [4:0] regAddr_t;

    // Result source: ALU, memory, PC plus 4, immediate
    typedef logic [1:0] resultSrc_t;

    // Store size, one-hot: byte 1, half 2, word 4
    typedef logic [2:0] memWrite_t;

    // Jump kind: none, jal, jalr
    typedef logic [1:0] jump_t;

    // ALU operation code
    typedef logic [2:0] aluCtrl_t;

    // Immediate format: I, S, B, J, U
    typedef logic [2:0] immSrc_t;

endpackage

`default_nettype wire

// File: design/ctrlBus.sv
`default_nettype none

interface ctrlBus;

    logic                   regWrite;
    decodePkg::resultSrc_t  resultSrc;
    decodePkg::memWrite_t   memWrite;
    decodePkg::jump_t       jump;
    logic                   branch;
    logic                   branchNe;
    decodePkg::aluCtrl_t    aluControl;
    logic                   aluSrc;
    logic                   illegal;
    decodePkg::word_t       imm;
    decodePkg::regAddr_t    rs1;
    decodePkg::regAddr_t    rs2;
    decodePkg::regAddr_t    rd;

    modport source (
        output regWrite, resultSrc, memWrite, jump, branch, branchNe,
        output aluControl, aluSrc, illegal, imm, rs1, rs2, rd
    );

    modport sink (
        input regWrite, resultSrc, memWrite, jump, branch, branchNe,
        input aluControl, aluSrc, illegal, imm, rs1, rs2, rd
    );

endinterface

`default_nettype wire

// File: design/controlDecoder.sv
`default_nettype none

`include "decode_defs.svh"

module controlDecoder (
    input  decodePkg::word_t instr_i,
    ctrlBus.source           ctrl
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   funct7b5;

    logic                   regWrite;
    decodePkg::resultSrc_t  resultSrc;
    decodePkg::memWrite_t   memWrite;
    decodePkg::jump_t       jump;
    logic                   branch;
    logic                   branchNe;
    decodePkg::aluCtrl_t    aluControl;
    logic                   aluSrc;
    logic                   illegal;
    decodePkg::immSrc_t     immSrc;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];

    always_comb begin
        regWrite   = 1'b0;
        resultSrc  = 2'd0;
        memWrite   = 3'd0;
        jump       = 2'd0;
        branch     = 1'b0;
        branchNe   = 1'b0;
        aluControl = `DECODE_ALU_ADD;
        aluSrc     = 1'b0;
        illegal    = 1'b0;
        immSrc     = `DECODE_IMM_I;

        case (opcode)
            `DECODE_OP_R, `DECODE_OP_I: begin
                regWrite = 1'b1;
                aluSrc   = (opcode == `DECODE_OP_I);
                case (funct3)
                    // Only the register form has sub
                    `DECODE_F3_ADD: aluControl = (opcode == `DECODE_OP_R && funct7b5) ?
                                                 `DECODE_ALU_SUB : `DECODE_ALU_ADD;
                    `DECODE_F3_SLL: aluControl = `DECODE_ALU_SLL;
                    `DECODE_F3_SLT: aluControl = `DECODE_ALU_SLT;
                    `DECODE_F3_XOR: aluControl = `DECODE_ALU_XOR;
                    `DECODE_F3_SRL: aluControl = `DECODE_ALU_SRL;
                    `DECODE_F3_OR:  aluControl = `DECODE_ALU_OR;
                    `DECODE_F3_AND: aluControl = `DECODE_ALU_AND;
                    default:        illegal    = 1'b1;
                endcase
            end
            `DECODE_OP_LOAD: begin
                regWrite  = 1'b1;
                resultSrc = 2'd1;
                aluSrc    = 1'b1;
                illegal   = (funct3 != `DECODE_F3_LW);
            end
            `DECODE_OP_STORE: begin
                aluSrc = 1'b1;
                immSrc = `DECODE_IMM_S;
                case (funct3)
                    `DECODE_F3_SB: memWrite = 3'b001;
                    `DECODE_F3_SH: memWrite = 3'b010;
                    `DECODE_F3_SW: memWrite = 3'b100;
                    default:       illegal  = 1'b1;
                endcase
            end
            `DECODE_OP_BRANCH: begin
                // Compare by subtraction in execute
                branch     = 1'b1;
                aluControl = `DECODE_ALU_SUB;
                immSrc     = `DECODE_IMM_B;
                branchNe   = (funct3 == `DECODE_F3_BNE);
                illegal    = (funct3 != `DECODE_F3_BEQ) && (funct3 != `DECODE_F3_BNE);
            end
            `DECODE_OP_JAL: begin
                regWrite  = 1'b1;
                resultSrc = 2'd2;
                jump      = 2'd1;
                immSrc    = `DECODE_IMM_J;
            end
            `DECODE_OP_JALR: begin
                regWrite  = 1'b1;
                resultSrc = 2'd2;
                jump      = 2'd2;
                aluSrc    = 1'b1;
                illegal   = (funct3 != `DECODE_F3_JALR);
            end
            `DECODE_OP_LUI: begin
                regWrite  = 1'b1;
                resultSrc = 2'd3;
                immSrc    = `DECODE_IMM_U;
            end
            default: illegal = 1'b1;
        endcase
    end

    // Sign-extended immediate
    always_comb begin
        case (immSrc)
            `DECODE_IMM_I: ctrl.imm = {{20{instr_i[31]}}, instr_i[31:20]};
            `DECODE_IMM_S: ctrl.imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            `DECODE_IMM_B: ctrl.imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                       instr_i[30:25], instr_i[11:8], 1'b0};
            `DECODE_IMM_J: ctrl.imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                       instr_i[20], instr_i[30:21], 1'b0};
            `DECODE_IMM_U: ctrl.imm = {instr_i[31:12], 12'b0};
            default:       ctrl.imm = '0;
        endcase
    end

    // Illegal instructions leave every control field inactive
    assign ctrl.regWrite   = illegal ? 1'b0 : regWrite;
    assign ctrl.resultSrc  = illegal ? 2'd0 : resultSrc;
    assign ctrl.memWrite   = illegal ? 3'd0 : memWrite;
    assign ctrl.jump       = illegal ? 2'd0 : jump;
    assign ctrl.branch     = illegal ? 1'b0 : branch;
    assign ctrl.branchNe   = illegal ? 1'b0 : branchNe;
    assign ctrl.aluControl = illegal ? 3'd0 : aluControl;
    assign ctrl.aluSrc     = illegal ? 1'b0 : aluSrc;
    assign ctrl.illegal    = illegal;

    assign ctrl.rs1 = instr_i[19:15];
    assign ctrl.rs2 = instr_i[24:20];
    assign ctrl.rd  = instr_i[11:7];

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none

`include "decode_defs.svh"

module regFile (
    input  logic                clk,
    input  logic                rstN_i,
    input  decodePkg::regAddr_t rs1_i,
    input  decodePkg::regAddr_t rs2_i,
    input  decodePkg::regAddr_t rd_i,
    input  logic                we_i,
    input  decodePkg::word_t    wd_i,
    output decodePkg::word_t    rd1_o,
    output decodePkg::word_t    rd2_o,
    output decodePkg::word_t    a0_o
);

    decodePkg::word_t regs [`DECODE_NREGS];

    logic writeEn;

    // x0 is never written
    assign writeEn = we_i && (rd_i != 5'd0);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `DECODE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Read with same-cycle write bypass
    always_comb begin
        if (rs1_i == 5'd0) begin
            rd1_o = '0;
        end else if (writeEn && rd_i == rs1_i) begin
            rd1_o = wd_i;
        end else begin
            rd1_o = regs[rs1_i];
        end
    end

    always_comb begin
        if (rs2_i == 5'd0) begin
            rd2_o = '0;
        end else if (writeEn && rd_i == rs2_i) begin
            rd2_o = wd_i;
        end else begin
            rd2_o = regs[rs2_i];
        end
    end

    // Debug view of a0
    assign a0_o = regs[`DECODE_A0];

endmodule

`default_nettype wire

// File: design/idExReg.sv
`default_nettype none

module idExReg (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    ctrlBus.sink                  ctrl,
    input  decodePkg::word_t      rd1_i,
    input  decodePkg::word_t      rd2_i,
    output logic                  regWriteE_o,
    output decodePkg::resultSrc_t resultSrcE_o,
    output decodePkg::memWrite_t  memWriteE_o,
    output decodePkg::jump_t      jumpE_o,
    output logic                  branchE_o,
    output logic                  branchNeE_o,
    output decodePkg::aluCtrl_t   aluControlE_o,
    output logic                  aluSrcE_o,
    output logic                  illegalE_o,
    output decodePkg::word_t      rd1E_o,
    output decodePkg::word_t      rd2E_o,
    output decodePkg::word_t      immE_o,
    output decodePkg::regAddr_t   rs1E_o,
    output decodePkg::regAddr_t   rs2E_o,
    output decodePkg::regAddr_t   rdE_o
);

    logic bubble;
    logic load;

    // Flush wins over stall
    assign bubble = flush_i;
    assign load   = !stall_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i || bubble) begin
            regWriteE_o   <= 1'b0;
            resultSrcE_o  <= '0;
            memWriteE_o   <= '0;
            jumpE_o       <= '0;
            branchE_o     <= 1'b0;
            branchNeE_o   <= 1'b0;
            aluControlE_o <= '0;
            aluSrcE_o     <= 1'b0;
            illegalE_o    <= 1'b0;
            rd1E_o        <= '0;
            rd2E_o        <= '0;
            immE_o        <= '0;
            rs1E_o        <= '0;
            rs2E_o        <= '0;
            rdE_o         <= '0;
        end else if (load) begin
            regWriteE_o   <= ctrl.regWrite;
            resultSrcE_o  <= ctrl.resultSrc;
            memWriteE_o   <= ctrl.memWrite;
            jumpE_o       <= ctrl.jump;
            branchE_o     <= ctrl.branch;
            branchNeE_o   <= ctrl.branchNe;
            aluControlE_o <= ctrl.aluControl;
            aluSrcE_o     <= ctrl.aluSrc;
            illegalE_o    <= ctrl.illegal;
            rd1E_o        <= rd1_i;
            rd2E_o        <= rd2_i;
            immE_o        <= ctrl.imm;
            rs1E_o        <= ctrl.rs1;
            rs2E_o        <= ctrl.rs2;
            rdE_o         <= ctrl.rd;
        end
    end

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`default_nettype none

module decodeStage (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  decodePkg::word_t      instrD_i,
    // Write-back port
    input  logic                  regWriteW_i,
    input  decodePkg::regAddr_t   rdW_i,
    input  decodePkg::word_t      resultW_i,
    // Pipeline control
    input  logic                  stallD_i,
    input  logic                  flushE_i,
    // E-stage slot
    output logic                  regWriteE_o,
    output decodePkg::resultSrc_t resultSrcE_o,
    output decodePkg::memWrite_t  memWriteE_o,
    output decodePkg::jump_t      jumpE_o,
    output logic                  branchE_o,
    output logic                  branchNeE_o,
    output decodePkg::aluCtrl_t   aluControlE_o,
    output logic                  aluSrcE_o,
    output logic                  illegalE_o,
    output decodePkg::word_t      rd1E_o,
    output decodePkg::word_t      rd2E_o,
    output decodePkg::word_t      immE_o,
    output decodePkg::regAddr_t   rs1E_o,
    output decodePkg::regAddr_t   rs2E_o,
    output decodePkg::regAddr_t   rdE_o,
    output decodePkg::word_t      a0_o
);

    ctrlBus ctrlD ();

    decodePkg::word_t rd1D;
    decodePkg::word_t rd2D;

    controlDecoder decoder (
        .instr_i (instrD_i),
        .ctrl    (ctrlD.source)
    );

    regFile regs (
        .clk    (clk),
        .rstN_i (rstN_i),
        .rs1_i  (ctrlD.rs1),
        .rs2_i  (ctrlD.rs2),
        .rd_i   (rdW_i),
        .we_i   (regWriteW_i),
        .wd_i   (resultW_i),
        .rd1_o  (rd1D),
        .rd2_o  (rd2D),
        .a0_o   (a0_o)
    );

    idExReg pipeReg (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .stall_i       (stallD_i),
        .flush_i       (flushE_i),
        .ctrl          (ctrlD.sink),
        .rd1_i         (rd1D),
        .rd2_i         (rd2D),
        .regWriteE_o   (regWriteE_o),
        .resultSrcE_o  (resultSrcE_o),
        .memWriteE_o   (memWriteE_o),
        .jumpE_o       (jumpE_o),
        .branchE_o     (branchE_o),
        .branchNeE_o   (branchNeE_o),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .illegalE_o    (illegalE_o),
        .rd1E_o        (rd1E_o),
        .rd2E_o        (rd2E_o),
        .immE_o        (immE_o),
        .rs1E_o        (rs1E_o),
        .rs2E_o        (rs2E_o),
        .rdE_o         (rdE_o)
    );

endmodule

`default_nettype wire

// File: tests/decodeTb.sv
`default_nettype none

`include "decode_defs.svh"

module decodeTb;

    localparam int NumCycles   = 3000;
    localparam int ResetLimit  = 20;
    localparam int FinishLimit = 50;

    typedef struct packed {
        logic                  regWrite;
        decodePkg::resultSrc_t resultSrc;
        decodePkg::memWrite_t  memWrite;
        decodePkg::jump_t      jump;
        logic                  branch;
        logic                  branchNe;
        decodePkg::aluCtrl_t   aluControl;
        logic                  aluSrc;
        logic                  illegal;
    } ctrlFields_t;

    typedef struct packed {
        ctrlFields_t      ctrl;
        decodePkg::word_t imm;
    } decoded_t;

    logic                  clk = 1'b0;
    logic                  rstN;
    decodePkg::word_t      instrD;
    logic                  regWriteW;
    decodePkg::regAddr_t   rdW;
    decodePkg::word_t      resultW;
    logic                  stallD;
    logic                  flushE;
    logic                  regWriteE;
    decodePkg::resultSrc_t resultSrcE;
    decodePkg::memWrite_t  memWriteE;
    decodePkg::jump_t      jumpE;
    logic                  branchE;
    logic                  branchNeE;
    decodePkg::aluCtrl_t   aluControlE;
    logic                  aluSrcE;
    logic                  illegalE;
    decodePkg::word_t      rd1E;
    decodePkg::word_t      rd2E;
    decodePkg::word_t      immE;
    decodePkg::regAddr_t   rs1E;
    decodePkg::regAddr_t   rs2E;
    decodePkg::regAddr_t   rdE;
    decodePkg::word_t      a0;

    // Register model and the expected E-stage slot
    decodePkg::word_t    modelRegs [`DECODE_NREGS];
    ctrlFields_t         expCtrl;
    decodePkg::word_t    expRd1;
    decodePkg::word_t    expRd2;
    decodePkg::word_t    expImm;
    decodePkg::regAddr_t expRs1;
    decodePkg::regAddr_t expRs2;
    decodePkg::regAddr_t expRd;

    int     checkCount = 0;
    integer seed = 32'ha425f1c2;

    decodeStage uut (
        .clk           (clk),
        .rstN_i        (rstN),
        .instrD_i      (instrD),
        .regWriteW_i   (regWriteW),
        .rdW_i         (rdW),
        .resultW_i     (resultW),
        .stallD_i      (stallD),
        .flushE_i      (flushE),
        .regWriteE_o   (regWriteE),
        .resultSrcE_o  (resultSrcE),
        .memWriteE_o   (memWriteE),
        .jumpE_o       (jumpE),
        .branchE_o     (branchE),
        .branchNeE_o   (branchNeE),
        .aluControlE_o (aluControlE),
        .aluSrcE_o     (aluSrcE),
        .illegalE_o    (illegalE),
        .rd1E_o        (rd1E),
        .rd2E_o        (rd2E),
        .immE_o        (immE),
        .rs1E_o        (rs1E),
        .rs2E_o        (rs2E),
        .rdE_o         (rdE),
        .a0_o          (a0)
    );

    always #10 clk = ~clk;

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic decodePkg::aluCtrl_t aluFor(input logic [2:0] f3, input logic isSub);
        case (f3)
            `DECODE_F3_ADD: return isSub ? `DECODE_ALU_SUB : `DECODE_ALU_ADD;
            `DECODE_F3_SLL: return `DECODE_ALU_SLL;
            `DECODE_F3_SLT: return `DECODE_ALU_SLT;
            `DECODE_F3_XOR: return `DECODE_ALU_XOR;
            `DECODE_F3_SRL: return `DECODE_ALU_SRL;
            `DECODE_F3_OR:  return `DECODE_ALU_OR;
            `DECODE_F3_AND: return `DECODE_ALU_AND;
            default:        return `DECODE_ALU_ADD;
        endcase
    endfunction

    function automatic decodePkg::word_t immOf(input decodePkg::word_t w,
                                               input decodePkg::immSrc_t fmt);
        case (fmt)
            `DECODE_IMM_S: return {{20{w[31]}}, w[31:25], w[11:7]};
            `DECODE_IMM_B: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            `DECODE_IMM_J: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            `DECODE_IMM_U: return {w[31:12], 12'h000};
            default:       return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic decoded_t decodeRef(input decodePkg::word_t instr);
        decoded_t           d;
        decodePkg::immSrc_t fmt;
        logic [6:0]         op;
        logic [2:0]         f3;
        d   = '0;
        fmt = `DECODE_IMM_I;
        op  = instr[6:0];
        f3  = instr[14:12];
        case (op)
            `DECODE_OP_R, `DECODE_OP_I: begin
                d.ctrl.regWrite   = 1'b1;
                d.ctrl.aluSrc     = (op == `DECODE_OP_I);
                d.ctrl.aluControl = aluFor(f3, (op == `DECODE_OP_R) && instr[30]);
                d.ctrl.illegal    = (f3 == 3'b011);
            end
            `DECODE_OP_LOAD: begin
                d.ctrl.regWrite  = 1'b1;
                d.ctrl.resultSrc = 2'd1;
                d.ctrl.aluSrc    = 1'b1;
                d.ctrl.illegal   = (f3 != `DECODE_F3_LW);
            end
            `DECODE_OP_STORE: begin
                fmt             = `DECODE_IMM_S;
                d.ctrl.aluSrc   = 1'b1;
                d.ctrl.memWrite = 3'b001 << f3;
                d.ctrl.illegal  = (f3 > 3'd2);
            end
            `DECODE_OP_BRANCH: begin
                fmt               = `DECODE_IMM_B;
                d.ctrl.branch     = 1'b1;
                d.ctrl.aluControl = `DECODE_ALU_SUB;
                d.ctrl.branchNe   = (f3 == `DECODE_F3_BNE);
                d.ctrl.illegal    = (f3 > 3'd1);
            end
            `DECODE_OP_JAL: begin
                fmt              = `DECODE_IMM_J;
                d.ctrl.regWrite  = 1'b1;
                d.ctrl.resultSrc = 2'd2;
                d.ctrl.jump      = 2'd1;
            end
            `DECODE_OP_JALR: begin
                d.ctrl.regWrite  = 1'b1;
                d.ctrl.resultSrc = 2'd2;
                d.ctrl.jump      = 2'd2;
                d.ctrl.aluSrc    = 1'b1;
                d.ctrl.illegal   = (f3 != `DECODE_F3_JALR);
            end
            `DECODE_OP_LUI: begin
                fmt              = `DECODE_IMM_U;
                d.ctrl.regWrite  = 1'b1;
                d.ctrl.resultSrc = 2'd3;
            end
            default: d.ctrl.illegal = 1'b1;
        endcase
        // Illegal means all control inactive
        if (d.ctrl.illegal) begin
            d.ctrl         = '0;
            d.ctrl.illegal = 1'b1;
        end
        d.imm = immOf(instr, fmt);
        return d;
    endfunction

    function automatic decodePkg::word_t makeInstr();
        decodePkg::word_t w;
        logic [2:0]       f3;
        int               kind;
        w        = $random(seed);
        // Small register range so that reads and write-backs collide
        w[19:15] = 5'(randBelow(12));
        w[24:20] = 5'(randBelow(12));
        w[11:7]  = 5'(randBelow(12));
        kind     = randBelow(9);
        f3       = 3'(randBelow(8));
        case (kind)
            0: begin
                f3       = (f3 == 3'b011) ? 3'b000 : f3;
                w[6:0]   = `DECODE_OP_R;
                w[31:25] = (f3 == 3'b000 && randBelow(2) == 1) ? 7'b0100000 : 7'b0000000;
            end
            1: begin
                f3     = (f3 == 3'b011) ? 3'b000 : f3;
                w[6:0] = `DECODE_OP_I;
            end
            2: begin
                f3     = `DECODE_F3_LW;
                w[6:0] = `DECODE_OP_LOAD;
            end
            3: begin
                f3     = `DECODE_F3_JALR;
                w[6:0] = `DECODE_OP_JALR;
            end
            4: begin
                f3     = 3'(randBelow(3));
                w[6:0] = `DECODE_OP_STORE;
            end
            5: begin
                f3     = 3'(randBelow(2));
                w[6:0] = `DECODE_OP_BRANCH;
            end
            6: w[6:0] = `DECODE_OP_JAL;
            7: w[6:0] = `DECODE_OP_LUI;
            // Any other kind keeps the whole random word
            default: ;
        endcase
        if (kind < 6) begin
            w[14:12] = f3;
        end
        return w;
    endfunction

    // Register read in the current cycle with bypass
    function automatic decodePkg::word_t readModel(input decodePkg::regAddr_t a);
        if (a == 5'd0) begin
            return '0;
        end
        if (regWriteW && rdW == a) begin
            return resultW;
        end
        return modelRegs[a];
    endfunction

    task automatic setBubble();
        expCtrl = '0;
        expRd1  = '0;
        expRd2  = '0;
        expImm  = '0;
        expRs1  = '0;
        expRs2  = '0;
        expRd   = '0;
    endtask

    task automatic failRun();
        $display("Finished with errors");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic checkCtrl(input ctrlFields_t got, input ctrlFields_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: control fields got %h expected %h", $time, got, exp);
            failRun();
        end
    endtask

    task automatic checkWord(input string what, input decodePkg::word_t got,
                             input decodePkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            failRun();
        end
    endtask

    task automatic checkReg(input string what, input decodePkg::regAddr_t got,
                            input decodePkg::regAddr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            failRun();
        end
    endtask

    // Expected slot follows reset, flush, stall and write-back
    always @(posedge clk) begin
        decoded_t d;
        if (!rstN) begin
            setBubble();
            for (int i = 0; i < `DECODE_NREGS; i++) begin
                modelRegs[i] = '0;
            end
        end else begin
            if (flushE) begin
                setBubble();
            end else if (!stallD) begin
                d       = decodeRef(instrD);
                expCtrl = d.ctrl;
                expImm  = d.imm;
                expRs1  = instrD[19:15];
                expRs2  = instrD[24:20];
                expRd   = instrD[11:7];
                expRd1  = readModel(instrD[19:15]);
                expRd2  = readModel(instrD[24:20]);
            end
            if (regWriteW && rdW != 5'd0) begin
                modelRegs[rdW] = resultW;
            end
        end
    end

    always @(negedge clk) begin
        ctrlFields_t got;
        got = {regWriteE, resultSrcE, memWriteE, jumpE, branchE, branchNeE,
               aluControlE, aluSrcE, illegalE};
        checkCtrl(got, expCtrl);
        checkWord("rd1E", rd1E, expRd1);
        checkWord("rd2E", rd2E, expRd2);
        checkWord("immE", immE, expImm);
        checkWord("a0", a0, modelRegs[`DECODE_A0]);
        checkReg("rs1E", rs1E, expRs1);
        checkReg("rs2E", rs2E, expRs2);
        checkReg("rdE", rdE, expRd);
        checkCount++;
    end

    initial begin : resetGen
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    end

    initial begin : stimulus
        int               waited;
        int               target;
        decodePkg::word_t nextInstr;
        instrD    = '0;
        regWriteW = 1'b0;
        rdW       = '0;
        resultW   = '0;
        stallD    = 1'b0;
        flushE    = 1'b0;
        setBubble();
        for (int i = 0; i < `DECODE_NREGS; i++) begin
            modelRegs[i] = '0;
        end

        waited = 0;
        while (rstN !== 1'b1 && waited < ResetLimit) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            failRun();
        end

        for (int n = 0; n < NumCycles; n++) begin
            @(posedge clk);
            nextInstr = makeInstr();
            instrD    <= nextInstr;
            regWriteW <= (randBelow(3) != 0);
            resultW   <= $random(seed);
            // Aim some write-backs at the new rs1 to hit the bypass
            if (randBelow(4) == 0) begin
                rdW <= nextInstr[19:15];
            end else begin
                rdW <= 5'(randBelow(12));
            end
            stallD <= (randBelow(8) == 0);
            flushE <= (randBelow(10) == 0);
        end

        target = checkCount + 2;
        waited = 0;
        while (checkCount < target && waited < FinishLimit) begin
            @(posedge clk);
            waited++;
        end
        if (checkCount < target) begin
            $display("Timeout: output checks stopped before the end of the run");
            failRun();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
design/decodePkg.sv
design/ctrlBus.sv
design/controlDecoder.sv
design/regFile.sv
design/idExReg.sv
design/decodeStage.sv
tests/decodeTb.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --top-module decodeTb -f tb.f -o decodeSim

./obj_dir/decodeSim
